//--- hw/gprf_cfg_pkg.sv
// Register file configuration: data width, register and thread counts, bank geometry
package gprf_cfg_pkg;

   // Datapath
   localparam int DATA_W = 32;                         // Register width in bits

   // Per-thread register set
   localparam int REG_CNT = 32;                        // R0 to R31
   localparam int REG_AW = $clog2(REG_CNT);            // Register field width, 5

   // Hardware threads sharing one bank
   localparam int THREAD_CNT = 2;                      // Alternating by phase

   // Bank geometry
   // Thread bit sits above the register number
   localparam int BANK_AW = REG_AW + $clog2(THREAD_CNT);   // 6, top bit is thread
   localparam int BANK_DEPTH = REG_CNT * THREAD_CNT;       // 64 entries

   // Low zero bits appended to the link address
   localparam int RPC_LSB = 2;                         // Word aligned PC

endpackage

//--- hw/gprf_isa_pkg.sv
// Instruction set view of the register file: word formats, result sources, load lanes
package gprf_isa_pkg;

   // Field widths
   localparam int OPC_W = 6;                           // Major opcode
   localparam int FUNC_W = 11;                         // A-format function bits
   localparam int IMM_W = 16;                          // B-format immediate

   // Opcode bit that marks the B format (instruction bit 29)
   localparam int FMT_B_BIT = 3;

   // One instruction word, two decodings
   typedef union packed {
      struct packed {
         logic [OPC_W-1:0] opcode;                     // Bits 31:26
         logic [gprf_cfg_pkg::REG_AW-1:0] rd;          // Bits 25:21
         logic [gprf_cfg_pkg::REG_AW-1:0] ra;          // Bits 20:16
         logic [gprf_cfg_pkg::REG_AW-1:0] rb;          // Bits 15:11
         logic [FUNC_W-1:0] func;                      // Bits 10:0
      } fmt_a;
      struct packed {
         logic [OPC_W-1:0] opcode;                     // Same opcode slot
         logic [gprf_cfg_pkg::REG_AW-1:0] rd;          // Same rd slot
         logic [gprf_cfg_pkg::REG_AW-1:0] ra;          // Same ra slot
         logic [IMM_W-1:0] imm;                        // Bits 15:0, signed
      } fmt_b;
   } instr_u;

   // Result source codes, 3 is a hole
   localparam logic [2:0] SRC_NOP = 3'd0;              // Nothing retires
   localparam logic [2:0] SRC_ALU = 3'd1;              // ALU result
   localparam logic [2:0] SRC_RPC = 3'd2;              // PC link
   localparam logic [2:0] SRC_MEM = 3'd4;              // Load or extension bus
   localparam logic [2:0] SRC_MUL = 3'd5;              // Multiplier
   localparam logic [2:0] SRC_BSF = 3'd6;              // Barrel shifter
   localparam logic [2:0] SRC_SFR = 3'd7;              // Special register

   // Load lane selects, one bit per byte lane
   localparam logic [3:0] LANE_B3 = 4'h8;              // Byte 31:24
   localparam logic [3:0] LANE_B2 = 4'h4;              // Byte 23:16
   localparam logic [3:0] LANE_B1 = 4'h2;              // Byte 15:8
   localparam logic [3:0] LANE_B0 = 4'h1;              // Byte 7:0
   localparam logic [3:0] LANE_H1 = 4'hC;              // Upper halfword
   localparam logic [3:0] LANE_H0 = 4'h3;              // Lower halfword
   localparam logic [3:0] LANE_W = 4'hF;               // Full word
   localparam logic [3:0] LANE_XSL = 4'h0;             // Extension bus

endpackage

//--- hw/gprf_operand_decode.sv
// Operand decode: thread-tagged bank read addresses and operand B selection
`timescale 1ns/10ps

module gprf_operand_decode (
   input  gprf_isa_pkg::instr_u                    ich_dat_i,  // Fetched word
   input  logic                                    gpha_i,     // Reading thread
   input  logic [gprf_cfg_pkg::DATA_W-1:0]         opb_reg_i,  // Raw rb from bank B
   output logic [gprf_cfg_pkg::BANK_AW-1:0]        rd_adr_o,   // Bank D read address
   output logic [gprf_cfg_pkg::BANK_AW-1:0]        ra_adr_o,   // Bank A read address
   output logic [gprf_cfg_pkg::BANK_AW-1:0]        rb_adr_o,   // Bank B read address
   output logic [gprf_cfg_pkg::DATA_W-1:0]         opb_o       // Operand B
);

   // Register fields of the word
   logic [gprf_cfg_pkg::REG_AW-1:0] rd_fld;
   logic [gprf_cfg_pkg::REG_AW-1:0] ra_fld;
   logic [gprf_cfg_pkg::REG_AW-1:0] rb_fld;

   // Immediate path
   logic [gprf_isa_pkg::IMM_W-1:0]  imm_fld;
   logic [gprf_cfg_pkg::DATA_W-1:0] imm_sext;

   // Format flag
   logic                            fmt_b;

   // rd and ra share slots in both formats
   assign rd_fld = ich_dat_i.fmt_a.rd;                 // Bits 25:21
   assign ra_fld = ich_dat_i.fmt_a.ra;                 // Bits 20:16
   assign rb_fld = ich_dat_i.fmt_a.rb;                 // Only meaningful in A format

   assign imm_fld = ich_dat_i.fmt_b.imm;               // Bits 15:0

   // Opcode bit 3 picks the B format
   assign fmt_b = ich_dat_i.fmt_b.opcode[gprf_isa_pkg::FMT_B_BIT];

   // Current thread owns the upper address bit
   assign rd_adr_o = {gpha_i, rd_fld};                 // Destination as source
   assign ra_adr_o = {gpha_i, ra_fld};                 // Operand A
   assign rb_adr_o = {gpha_i, rb_fld};                 // Operand B register

   // Sign-extend the 16-bit immediate to the full word
   assign imm_sext = {
      {(gprf_cfg_pkg::DATA_W - gprf_isa_pkg::IMM_W){imm_fld[gprf_isa_pkg::IMM_W-1]}},
      imm_fld
   };

   // Immediate for B format, register otherwise
   always_comb begin
      if (fmt_b) begin
         opb_o = imm_sext;                             // Immediate operand
      end else begin
         opb_o = opb_reg_i;                            // rb contents
      end
   end

endmodule

//--- hw/gprf_dual_bank.sv
// Register bank: 64x32 LUT-style memory, synchronous write, asynchronous read
`timescale 1ns/10ps

module gprf_dual_bank (
   input  logic                                gclk,    // Core clock
   input  logic                                ena_i,   // Pipeline enable
   input  logic                                wre_i,   // Write request
   input  logic [gprf_cfg_pkg::BANK_AW-1:0]    wadr_i,  // {thread, rd}
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     wdat_i,  // Write-back value
   input  logic [gprf_cfg_pkg::BANK_AW-1:0]    radr_i,  // {thread, reg}
   output logic [gprf_cfg_pkg::DATA_W-1:0]     rdat_o   // Read data
);

   // Both threads in one array, thread is the top address bit
   logic [gprf_cfg_pkg::DATA_W-1:0] mem_q [0:gprf_cfg_pkg::BANK_DEPTH-1];

   // Qualified write strobe
   logic                            wr_go;

   assign wr_go = ena_i & wre_i;                       // Held off while stalled

   // Single write port
   always_ff @(posedge gclk) begin
      if (wr_go) begin
         mem_q[wadr_i] <= wdat_i;                      // Lands on the enabled edge
      end
   end

   // Asynchronous read port
   // New data shows from the edge after the write
   assign rdat_o = mem_q[radr_i];                      // Combinational lookup

endmodule

//--- hw/gprf_load_sizer.sv
// Load sizer: picks byte, halfword or word lanes of load data, or extension bus data
`timescale 1ns/10ps

module gprf_load_sizer (
   input  logic [3:0]                          sel_mx_i,   // Lane select code
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     dwb_mx_i,   // Data bus read word
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     xwb_mx_i,   // Extension bus word
   output logic [gprf_cfg_pkg::DATA_W-1:0]     mem_dat_o   // Sized load result
);

   // Zero fill widths
   localparam int BYTE_PAD = gprf_cfg_pkg::DATA_W - 8;
   localparam int HALF_PAD = gprf_cfg_pkg::DATA_W - 16;

   always_comb begin
      case (sel_mx_i)
         // Single bytes, big-endian lane order
         gprf_isa_pkg::LANE_B3: begin
            mem_dat_o = {{BYTE_PAD{1'b0}}, dwb_mx_i[31:24]};   // Byte 0 of word
         end
         gprf_isa_pkg::LANE_B2: begin
            mem_dat_o = {{BYTE_PAD{1'b0}}, dwb_mx_i[23:16]};   // Byte 1
         end
         gprf_isa_pkg::LANE_B1: begin
            mem_dat_o = {{BYTE_PAD{1'b0}}, dwb_mx_i[15:8]};    // Byte 2
         end
         gprf_isa_pkg::LANE_B0: begin
            mem_dat_o = {{BYTE_PAD{1'b0}}, dwb_mx_i[7:0]};     // Byte 3
         end
         // Halfwords
         gprf_isa_pkg::LANE_H1: begin
            mem_dat_o = {{HALF_PAD{1'b0}}, dwb_mx_i[31:16]};   // Upper half
         end
         gprf_isa_pkg::LANE_H0: begin
            mem_dat_o = {{HALF_PAD{1'b0}}, dwb_mx_i[15:0]};    // Lower half
         end
         // Full word
         gprf_isa_pkg::LANE_W: begin
            mem_dat_o = dwb_mx_i;                              // No sizing
         end
         // Extension bus takes the zero code
         gprf_isa_pkg::LANE_XSL: begin
            mem_dat_o = xwb_mx_i;                              // FSL style get
         end
         default: begin
            mem_dat_o = 'x;                                    // Illegal lane mix
         end
      endcase
   end

endmodule

//--- hw/gprf_writeback_select.sv
// Write-back stage: destination pipeline register, enable, source select and write address
`timescale 1ns/10ps

module gprf_writeback_select (
   input  logic                                gclk,       // Core clock
   input  logic                                grst,       // Sync reset
   input  logic                                dena_i,     // Pipeline enable
   input  logic                                gpha_i,     // Reading thread
   input  logic [gprf_cfg_pkg::REG_AW-1:0]     rd_ex_i,    // Destination leaving execute
   input  logic [2:0]                          mux_ex_i,   // Result source leaving execute
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     mem_dat_i,  // From load sizer
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     alu_mx_i,   // ALU result
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     mul_mx_i,   // Multiplier result
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     bsf_mx_i,   // Shifter result
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     sfr_mx_i,   // Special register read
   input  logic [gprf_cfg_pkg::DATA_W-3:0]     rpc_mx_i,   // PC link, bits 31:2
   output logic [gprf_cfg_pkg::BANK_AW-1:0]    wr_adr_o,   // {~phase, rd}
   output logic [gprf_cfg_pkg::DATA_W-1:0]     wr_dat_o,   // Value to write
   output logic                                wr_en_o     // Bank write request
);

   // Pipeline state of the retiring instruction
   logic [gprf_cfg_pkg::REG_AW-1:0] rd_q;              // Held destination
   logic [2:0]                      mux_q;             // Held source code
   logic                            wrb_q;             // Write pending

   // Selected value
   logic [gprf_cfg_pkg::DATA_W-1:0] wr_val;

   always_ff @(posedge gclk) begin
      if (grst) begin
         rd_q  <= '0;                                  // Points at R0
         mux_q <= gprf_isa_pkg::SRC_NOP;               // Forces a zero value
         wrb_q <= 1'b0;
      end else if (dena_i) begin
         wrb_q <= (|rd_ex_i) & (|mux_ex_i);            // R0 and NOP never write
         rd_q  <= rd_ex_i;
         mux_q <= mux_ex_i;
      end
   end

   // Source buses are held through the cycle after capture
   always_comb begin
      case (mux_q)
         gprf_isa_pkg::SRC_NOP: wr_val = '0;                         // Reset clears R0
         gprf_isa_pkg::SRC_ALU: wr_val = alu_mx_i;
         gprf_isa_pkg::SRC_RPC: begin
            wr_val = {rpc_mx_i, {gprf_cfg_pkg::RPC_LSB{1'b0}}};      // Word aligned link
         end
         gprf_isa_pkg::SRC_MEM: wr_val = mem_dat_i;                  // Load or XSL
         gprf_isa_pkg::SRC_MUL: wr_val = mul_mx_i;
         gprf_isa_pkg::SRC_BSF: wr_val = bsf_mx_i;
         gprf_isa_pkg::SRC_SFR: wr_val = sfr_mx_i;
         default:               wr_val = 'x;                         // Code 3 unused
      endcase
   end

   assign wr_dat_o = wr_val;

   // The other thread's half is written while this one reads
   assign wr_adr_o = {~gpha_i, rd_q};

   // Reset writes zero into R0 of whichever thread is off phase
   assign wr_en_o = grst | wrb_q;

endmodule

//--- hw/gprf_top.sv
// Register file top: decode, three read banks, load sizer and write-back path
`timescale 1ns/10ps

module gprf_top (
   input  logic                                gclk,       // Core clock
   input  logic                                grst,       // Sync reset
   input  logic                                dena_i,     // Pipeline enable
   input  logic                                gpha_i,     // Thread phase
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     ich_dat_i,  // Instruction word
   input  logic [gprf_cfg_pkg::REG_AW-1:0]     rd_ex_i,    // Destination in execute
   input  logic [2:0]                          mux_ex_i,   // Result source in execute
   input  logic [3:0]                          sel_mx_i,   // Load lane select
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     alu_mx_i,   // ALU
   input  logic [gprf_cfg_pkg::DATA_W-3:0]     rpc_mx_i,   // PC link 31:2
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     dwb_mx_i,   // Data bus read
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     xwb_mx_i,   // Extension bus read
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     mul_mx_i,   // Multiplier
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     bsf_mx_i,   // Barrel shifter
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     sfr_mx_i,   // Special registers
   output logic [gprf_cfg_pkg::DATA_W-1:0]     opa_o,      // Operand A
   output logic [gprf_cfg_pkg::DATA_W-1:0]     opb_o,      // Operand B or immediate
   output logic [gprf_cfg_pkg::DATA_W-1:0]     opd_o       // Store data, rd contents
);

   // Read side
   logic [gprf_cfg_pkg::BANK_AW-1:0] rd_adr;           // Bank D address
   logic [gprf_cfg_pkg::BANK_AW-1:0] ra_adr;           // Bank A address
   logic [gprf_cfg_pkg::BANK_AW-1:0] rb_adr;           // Bank B address
   logic [gprf_cfg_pkg::DATA_W-1:0]  opb_reg;          // Raw rb before immediate mux

   // Write side, shared by all banks
   logic [gprf_cfg_pkg::DATA_W-1:0]  mem_data;         // Sized load result
   logic [gprf_cfg_pkg::BANK_AW-1:0] wr_adr;
   logic [gprf_cfg_pkg::DATA_W-1:0]  wr_dat;
   logic                             wr_en;

   gprf_operand_decode u_decode (
      .ich_dat_i (ich_dat_i),                          // Packed word into union
      .gpha_i    (gpha_i),
      .opb_reg_i (opb_reg),
      .rd_adr_o  (rd_adr),
      .ra_adr_o  (ra_adr),
      .rb_adr_o  (rb_adr),
      .opb_o     (opb_o)
   );

   // Three copies give three read ports
   gprf_dual_bank bank_a (
      .gclk   (gclk),
      .ena_i  (dena_i),
      .wre_i  (wr_en),
      .wadr_i (wr_adr),
      .wdat_i (wr_dat),
      .radr_i (ra_adr),
      .rdat_o (opa_o)                                  // ra contents
   );

   gprf_dual_bank bank_b (
      .gclk   (gclk),
      .ena_i  (dena_i),
      .wre_i  (wr_en),
      .wadr_i (wr_adr),
      .wdat_i (wr_dat),
      .radr_i (rb_adr),
      .rdat_o (opb_reg)                                // rb contents
   );

   gprf_dual_bank bank_d (
      .gclk   (gclk),
      .ena_i  (dena_i),
      .wre_i  (wr_en),
      .wadr_i (wr_adr),
      .wdat_i (wr_dat),
      .radr_i (rd_adr),
      .rdat_o (opd_o)                                  // rd contents
   );

   gprf_load_sizer u_sizer (
      .sel_mx_i  (sel_mx_i),
      .dwb_mx_i  (dwb_mx_i),
      .xwb_mx_i  (xwb_mx_i),
      .mem_dat_o (mem_data)
   );

   gprf_writeback_select u_wb (
      .gclk      (gclk),
      .grst      (grst),
      .dena_i    (dena_i),
      .gpha_i    (gpha_i),
      .rd_ex_i   (rd_ex_i),
      .mux_ex_i  (mux_ex_i),
      .mem_dat_i (mem_data),
      .alu_mx_i  (alu_mx_i),
      .mul_mx_i  (mul_mx_i),
      .bsf_mx_i  (bsf_mx_i),
      .sfr_mx_i  (sfr_mx_i),
      .rpc_mx_i  (rpc_mx_i),
      .wr_adr_o  (wr_adr),
      .wr_dat_o  (wr_dat),
      .wr_en_o   (wr_en)
   );

endmodule

//--- testbench/gprf_sva.sv
// Write-back checker: reset write, R0 guard and defined write data on the bank write port
`timescale 1ns/10ps

module gprf_sva (
   input  logic                                gclk,       // Core clock
   input  logic                                grst,       // Sync reset
   input  logic [gprf_cfg_pkg::REG_AW-1:0]     rd_q_i,     // Held destination
   input  logic                                wr_en_i,    // Bank write request
   input  logic [gprf_cfg_pkg::DATA_W-1:0]     wr_dat_i    // Value to write
);

   // Once the pipeline has cleared, reset writes zero into an R0
   a_rst_wen: assert property (@(posedge gclk) (grst && $past(grst)) |->
      (wr_en_i && (rd_q_i == '0) && (wr_dat_i == '0)))
      else $error("reset cycle does not write zero into R0");

   // Nothing pending once reset is released
   a_rst_release: assert property (@(posedge gclk) $fell(grst) |-> !wr_en_i)
      else $error("write enable high right after reset release");

   // R0 is read only outside reset
   a_r0_guard: assert property (@(posedge gclk) disable iff (grst)
      (rd_q_i == '0) |-> !wr_en_i)
      else $error("write requested for R0 outside reset");

   // Catches code 3 and illegal lane mixes
   a_wdat_known: assert property (@(posedge gclk) disable iff (grst)
      wr_en_i |-> !$isunknown(wr_dat_i))
      else $error("unknown write data with write enable high");

endmodule

// Attached to every write-back stage
bind gprf_writeback_select gprf_sva u_sva (
   .gclk     (gclk),
   .grst     (grst),
   .rd_q_i   (rd_q),
   .wr_en_i  (wr_en_o),
   .wr_dat_i (wr_dat_o)
);

//--- testbench/gprf_tb.sv
// Register file testbench: table driven writes per source and lane, stalls, thread and read checks
`timescale 1ns/10ps

module gprf_tb;

   localparam int CLK_HALF = 20;                       // 40 ns period
   localparam int NUM_ROWS = 18;
   localparam int TIMEOUT_CYC = NUM_ROWS * 8 + 20;     // Longest row is 7 cycles

   // One test row
   typedef struct packed {
      logic        thread;                             // Writing thread
      logic [4:0]  rd;                                 // Destination
      logic [2:0]  src;                                // Result source code
      logic [3:0]  lane;                               // Load lane select
      logic [31:0] val;                                // Value on the selected bus
      logic [1:0]  stall;                              // Cycles with dena low
      logic        fmt_b;                              // Read back with B format
   } row_t;

   logic        gclk;
   logic        grst;
   logic        dena;
   logic        gpha;
   logic [31:0] ich_dat;
   logic [4:0]  rd_ex;
   logic [2:0]  mux_ex;
   logic [3:0]  sel_mx;
   logic [31:0] alu_mx;
   logic [29:0] rpc_mx;
   logic [31:0] dwb_mx;
   logic [31:0] xwb_mx;
   logic [31:0] mul_mx;
   logic [31:0] bsf_mx;
   logic [31:0] sfr_mx;
   logic [31:0] opa;
   logic [31:0] opb;
   logic [31:0] opd;

   row_t        tbl [NUM_ROWS];
   logic [31:0] ref_q [64];                            // Expected bank contents
   logic [15:0] lfsr_q = 16'd33914;
   int          err_cnt = 0;
   int          pass_cnt = 0;
   int          cur_test = 0;
   int          cyc_cnt = 0;

   gprf_top uut (
      .gclk (gclk), .grst (grst), .dena_i (dena), .gpha_i (gpha),
      .ich_dat_i (ich_dat), .rd_ex_i (rd_ex), .mux_ex_i (mux_ex), .sel_mx_i (sel_mx),
      .alu_mx_i (alu_mx), .rpc_mx_i (rpc_mx), .dwb_mx_i (dwb_mx), .xwb_mx_i (xwb_mx),
      .mul_mx_i (mul_mx), .bsf_mx_i (bsf_mx), .sfr_mx_i (sfr_mx),
      .opa_o (opa), .opb_o (opb), .opd_o (opd)
   );

   initial begin
      gclk = 1'b0;
      forever #CLK_HALF gclk = ~gclk;
   end

   // Run limit
   always @(posedge gclk) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt >= TIMEOUT_CYC) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
         $display("tests failed");
         $finish;
      end
   end

   // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] w);
      w = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);                   // One step per bit
         w = {w[30:0], lfsr_q[0]};
      end
   endtask

   // Big-endian lanes, zero extended
   function automatic logic [31:0] lane_value(input logic [3:0] lane, input logic [31:0] v);
      case (lane)
         gprf_isa_pkg::LANE_B3:  return {24'h0, v[31:24]};
         gprf_isa_pkg::LANE_B2:  return {24'h0, v[23:16]};
         gprf_isa_pkg::LANE_B1:  return {24'h0, v[15:8]};
         gprf_isa_pkg::LANE_B0:  return {24'h0, v[7:0]};
         gprf_isa_pkg::LANE_H1:  return {16'h0, v[31:16]};
         gprf_isa_pkg::LANE_H0:  return {16'h0, v[15:0]};
         default:                return v;             // Word or extension bus
      endcase
   endfunction

   function automatic logic [31:0] source_value(input row_t r);
      case (r.src)
         gprf_isa_pkg::SRC_RPC: return {r.val[29:0], 2'b00};   // Word aligned link
         gprf_isa_pkg::SRC_MEM: return lane_value(r.lane, r.val);
         default:               return r.val;
      endcase
   endfunction

   // Filler on every bus, row value on the selected one
   task automatic drive_buses(input row_t r);
      logic [31:0] w;
      take_bits(32, alu_mx);
      take_bits(30, w);
      rpc_mx = w[29:0];
      take_bits(32, dwb_mx);
      take_bits(32, xwb_mx);
      take_bits(32, mul_mx);
      take_bits(32, bsf_mx);
      take_bits(32, sfr_mx);
      case (r.src)
         gprf_isa_pkg::SRC_ALU: alu_mx = r.val;
         gprf_isa_pkg::SRC_RPC: rpc_mx = r.val[29:0];
         gprf_isa_pkg::SRC_MUL: mul_mx = r.val;
         gprf_isa_pkg::SRC_BSF: bsf_mx = r.val;
         gprf_isa_pkg::SRC_SFR: sfr_mx = r.val;
         gprf_isa_pkg::SRC_MEM: begin
            if (r.lane == gprf_isa_pkg::LANE_XSL) xwb_mx = r.val;
            else dwb_mx = r.val;
         end
         default: ;                                    // NOP leaves filler
      endcase
   endtask

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp) else begin
         $display("mismatch test %0d %s: got %08h expected %08h", cur_test, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic load_table();
      tbl[0]  = '{1'b0, 5'd0,  gprf_isa_pkg::SRC_ALU, gprf_isa_pkg::LANE_W,  32'hDEADBEEF, 2'd0, 1'b1};
      tbl[1]  = '{1'b1, 5'd0,  gprf_isa_pkg::SRC_MUL, gprf_isa_pkg::LANE_W,  32'h12345678, 2'd0, 1'b1};
      tbl[2]  = '{1'b0, 5'd1,  gprf_isa_pkg::SRC_ALU, gprf_isa_pkg::LANE_W,  32'hA5A50001, 2'd0, 1'b0};
      tbl[3]  = '{1'b1, 5'd1,  gprf_isa_pkg::SRC_ALU, gprf_isa_pkg::LANE_W,  32'h5A5A0002, 2'd0, 1'b0};
      tbl[4]  = '{1'b0, 5'd2,  gprf_isa_pkg::SRC_RPC, gprf_isa_pkg::LANE_W,  32'h23456789, 2'd0, 1'b0};
      tbl[5]  = '{1'b0, 5'd3,  gprf_isa_pkg::SRC_MEM, gprf_isa_pkg::LANE_B3, 32'h11223344, 2'd0, 1'b0};
      tbl[6]  = '{1'b0, 5'd4,  gprf_isa_pkg::SRC_MEM, gprf_isa_pkg::LANE_B2, 32'h11223344, 2'd0, 1'b0};
      tbl[7]  = '{1'b1, 5'd5,  gprf_isa_pkg::SRC_MEM, gprf_isa_pkg::LANE_B1, 32'h8899AABB, 2'd0, 1'b0};
      tbl[8]  = '{1'b1, 5'd6,  gprf_isa_pkg::SRC_MEM, gprf_isa_pkg::LANE_B0, 32'h8899AABB, 2'd0, 1'b0};
      tbl[9]  = '{1'b0, 5'd7,  gprf_isa_pkg::SRC_MEM, gprf_isa_pkg::LANE_H1, 32'hCAFEF00D, 2'd0, 1'b0};
      tbl[10] = '{1'b0, 5'd8,  gprf_isa_pkg::SRC_MEM, gprf_isa_pkg::LANE_H0, 32'hCAFEF00D, 2'd0, 1'b0};
      tbl[11] = '{1'b1, 5'd9,  gprf_isa_pkg::SRC_MEM, gprf_isa_pkg::LANE_W,  32'h0BADC0DE, 2'd0, 1'b0};
      tbl[12] = '{1'b1, 5'd10, gprf_isa_pkg::SRC_MEM, gprf_isa_pkg::LANE_XSL, 32'h600DF00D, 2'd0, 1'b0};
      tbl[13] = '{1'b0, 5'd11, gprf_isa_pkg::SRC_MUL, gprf_isa_pkg::LANE_W,  32'h00010001, 2'd2, 1'b1};
      tbl[14] = '{1'b1, 5'd12, gprf_isa_pkg::SRC_BSF, gprf_isa_pkg::LANE_W,  32'h80000001, 2'd3, 1'b0};
      tbl[15] = '{1'b0, 5'd13, gprf_isa_pkg::SRC_SFR, gprf_isa_pkg::LANE_W,  32'h00008003, 2'd0, 1'b1};
      tbl[16] = '{1'b0, 5'd13, gprf_isa_pkg::SRC_NOP, gprf_isa_pkg::LANE_W,  32'hFFFFFFFF, 2'd0, 1'b0};
      tbl[17] = '{1'b1, 5'd31, gprf_isa_pkg::SRC_ALU, gprf_isa_pkg::LANE_W,  32'h7FFFFFFF, 2'd1, 1'b1};
   endtask

   task automatic run_row(input int idx);
      row_t        r;
      logic [5:0]  adr;
      logic [5:0]  oth;
      logic [31:0] exp_val;
      logic [31:0] w;
      logic [15:0] imm;
      int          fails_before;
      r = tbl[idx];
      cur_test = idx;
      fails_before = err_cnt;
      adr = {r.thread, r.rd};
      oth = {~r.thread, r.rd};
      // R0 and NOP keep the old contents
      if ((r.rd != 5'd0) && (r.src != gprf_isa_pkg::SRC_NOP)) exp_val = source_value(r);
      else exp_val = ref_q[adr];
      take_bits(16, w);
      imm = w[15:0];
      @(negedge gclk);                                 // Capture cycle
      dena = 1'b1;
      gpha = r.thread;
      rd_ex = r.rd;
      mux_ex = r.src;
      sel_mx = r.lane;
      drive_buses(r);
      repeat (r.stall) begin
         @(negedge gclk);
         dena = 1'b0;
         rd_ex = 5'd0;
         mux_ex = gprf_isa_pkg::SRC_NOP;
         gpha = ~gpha;                                 // Early write would show in next read
         ich_dat = {6'b000000, r.rd, 5'd0, 5'd1, 11'd0};
         #(CLK_HALF / 2);
         check_word("opd_o stalled", opd, ref_q[{gpha, r.rd}]);   // Write still held back
      end
      @(negedge gclk);                                 // Write cycle, other phase
      dena = 1'b1;
      gpha = ~r.thread;
      rd_ex = 5'd0;
      mux_ex = gprf_isa_pkg::SRC_NOP;
      ref_q[adr] = exp_val;
      @(negedge gclk);                                 // Read back in own thread
      gpha = r.thread;
      // ra on R0 and rb on R1 keep all three ports apart
      if (r.fmt_b) ich_dat = {6'b001000, r.rd, 5'd0, imm};
      else ich_dat = {6'b000000, r.rd, 5'd0, 5'd1, 11'd0};
      #(CLK_HALF / 2);
      check_word("opa_o", opa, ref_q[{r.thread, 5'd0}]);
      check_word("opd_o", opd, ref_q[adr]);
      if (r.fmt_b) check_word("opb_o", opb, {{16{imm[15]}}, imm});
      else check_word("opb_o", opb, ref_q[{r.thread, 5'd1}]);
      @(negedge gclk);                                 // Same number, other thread
      gpha = ~r.thread;
      #(CLK_HALF / 2);
      check_word("opa_o other thread", opa, ref_q[{~r.thread, 5'd0}]);
      check_word("opd_o other thread", opd, ref_q[oth]);
      if (err_cnt == fails_before) pass_cnt++;
      $display("test %0d thread %0d r%0d src %0d lane %h stall %0d: %s", idx, r.thread,
               r.rd, r.src, r.lane, r.stall, (err_cnt == fails_before) ? "ok" : "FAIL");
   endtask

   initial begin
      grst = 1'b1;
      dena = 1'b1;
      gpha = 1'b0;
      ich_dat = '0;
      rd_ex = '0;
      mux_ex = gprf_isa_pkg::SRC_NOP;
      sel_mx = gprf_isa_pkg::LANE_W;
      alu_mx = '0;
      rpc_mx = '0;
      dwb_mx = '0;
      xwb_mx = '0;
      mul_mx = '0;
      bsf_mx = '0;
      sfr_mx = '0;
      load_table();
      for (int i = 0; i < 64; i++) ref_q[i] = 'x;     // Unwritten
      @(negedge gclk);                                 // First edge clears rd and source
      repeat (2) begin
         gpha = ~gpha;                                 // Zero lands in each thread's R0
         @(negedge gclk);
      end
      grst = 1'b0;
      ref_q[0] = '0;
      ref_q[32] = '0;
      for (int i = 0; i < NUM_ROWS; i++) run_row(i);
      $display("summary: %0d of %0d rows ok, %0d mismatches", pass_cnt, NUM_ROWS, err_cnt);
      if (err_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- files.f
hw/gprf_cfg_pkg.sv
hw/gprf_isa_pkg.sv
hw/gprf_operand_decode.sv
hw/gprf_dual_bank.sv
hw/gprf_load_sizer.sv
hw/gprf_writeback_select.sv
hw/gprf_top.sv
testbench/gprf_sva.sv
testbench/gprf_tb.sv
